// ==== Bender.yml ====
package:
  name: dfs_clk_ctrl

sources:
  - files:
      - verilog/dfs_pkg.sv
      - verilog/dfs_clk_opt_ctrl.sv
      - verilog/dfs_prog_serializer.sv
      - verilog/dfs_top.sv
  - target: test
    files:
      - dv/dfs_properties.sv
      - dv/dfs_tb.sv

// ==== compile.f ====
verilog/dfs_pkg.sv
verilog/dfs_clk_opt_ctrl.sv
verilog/dfs_prog_serializer.sv
verilog/dfs_top.sv
dv/dfs_properties.sv
dv/dfs_tb.sv

// ==== dv/dfs_properties.sv ====
//--------------------------------------------------------------------------
// dfs port properties
// concurrent checks on the generator programming port, the requester
// strobes and the scaled domain reset, bound into the dfs top level.
//--------------------------------------------------------------------------

module dfs_properties (
   input logic clk,
   input logic rst_sys,
   input logic progen,
   input logic progdone,
   input logic freq_ack,
   input logic req_drop,
   input logic ddc_rst
);

   timeunit 1ns;
   timeprecision 1ps;

   // a load frame is the longest burst under progen.
   a_progen_burst : assert property (
      @(posedge clk) disable iff (rst_sys) progen [*10] |=> !progen
   ) else $error("progen held high for more than 10 cycles");

   // generator never sees a new command while it still reports done.
   a_progen_done : assert property (
      @(posedge clk) disable iff (rst_sys) !(progen && progdone)
   ) else $error("progen high while progdone is high");

   // ack and drop are mutually exclusive.
   a_ack_drop : assert property (
      @(posedge clk) disable iff (rst_sys) !(freq_ack && req_drop)
   ) else $error("freq_ack and req_drop high together");

   // scaled domain held in reset with the system.
   a_domain_rst : assert property (
      @(posedge clk) rst_sys |-> ddc_rst
   ) else $error("ddc_rst low while rst_sys is asserted");

endmodule

bind dfs_top dfs_properties i_props (
   .clk      (clk),
   .rst_sys  (rst_sys),
   .progen   (progen),
   .progdone (progdone),
   .freq_ack (freq_ack),
   .req_drop (req_drop),
   .ddc_rst  (ddc_rst)
);

// ==== dv/dfs_tb.sv ====
//--------------------------------------------------------------------------
// dfs testbench
// runs the top level through reset, the default setting, a sweep of all
// settings, a dropped request and random settings. a generator model
// decodes the serial frames and answers each go command with progdone.
//--------------------------------------------------------------------------

module dfs_tb
   import dfs_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int        CLK_PERIOD      = 10;
   localparam freq_sel_t DEFAULT_SEL     = 3'd3;
   localparam int        NUM_PROGRAMS    = 21;  // default, sweep, drop, frame, random.
   localparam int        MAX_PROG_CYCLES = 45;  // request to ack, longest delay.
   localparam int        WATCHDOG_NS     =
      (NUM_PROGRAMS * MAX_PROG_CYCLES + 3 + 1 + INIT_CYCLES) * 2 * CLK_PERIOD;

   // one run of bits seen under progen.
   typedef struct packed {
      logic [7:0]  len;
      logic [1:0]  op;                     // first two bits, lsb first.
      clk_factor_t factor;
   } frame_t;

   logic        clk     = 1'b0;
   logic        rst_sys = 1'b0;
   logic        req_valid;
   freq_sel_t   req_sel;
   logic        req_drop;
   logic        freq_ack;
   freq_sel_t   cur_sel;
   logic        ddc_rst;
   logic        progen;
   logic        progdata;
   logic        progdone;

   frame_t      frame_q[$];                // decoded load frames.
   int          go_cnt     = 0;            // go commands seen.
   int          go_checked = 0;
   int          run_len    = 0;
   logic [15:0] run_bits;

   dfs_top #(
      .DEFAULT_SEL (DEFAULT_SEL)
   ) i_dut (
      .clk       (clk),
      .rst_sys   (rst_sys),
      .req_valid (req_valid),
      .req_sel   (req_sel),
      .req_drop  (req_drop),
      .freq_ack  (freq_ack),
      .cur_sel   (cur_sel),
      .ddc_rst   (ddc_rst),
      .progen    (progen),
      .progdata  (progdata),
      .progdone  (progdone)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //-----------------------------------------------------------------------
   // generator model
   //-----------------------------------------------------------------------

   // collects bits while progen is high, decodes when it falls.
   always @(posedge clk) begin
      if (rst_sys) begin
         run_len = 0;
      end else if (progen) begin
         if (run_len < 16) begin
            run_bits[run_len] = progdata;
         end
         run_len = run_len + 1;
      end else if (run_len != 0) begin
         if ((run_len == 1) && !run_bits[0]) begin
            go_cnt = go_cnt + 1;           // go command.
         end else begin
            frame_q.push_back('{len: 8'(run_len), op: run_bits[1:0],
                                factor: run_bits[9:2]});
         end
         run_len = 0;
      end
   end

   // done level after a random delay, cleared by the ack.
   initial begin : generator_done
      int served;
      int delay;
      served   = 0;
      progdone = 1'b0;
      forever begin
         wait (go_cnt != served);
         served = served + 1;
         delay  = 2 + ($urandom % 8);     // 2 to 9 cycles.
         repeat (delay) @(posedge clk);
         progdone <= 1'b1;
         do begin
            @(posedge clk);
         end while (freq_ack !== 1'b1);
         progdone <= 1'b0;
      end
   end

   //-----------------------------------------------------------------------
   // reference and checks
   //-----------------------------------------------------------------------

   // factor table for each setting.
   function automatic prog_cmd_t lookup_factors(input freq_sel_t sel);
      case (sel)
         3'd0:    lookup_factors = '{multi: 8'd1, div: 8'd2};
         3'd1:    lookup_factors = '{multi: 8'd6, div: 8'd11};
         3'd2:    lookup_factors = '{multi: 8'd1, div: 8'd13};
         3'd3:    lookup_factors = '{multi: 8'd4, div: 8'd11};
         3'd4:    lookup_factors = '{multi: 8'd1, div: 8'd5};
         3'd5:    lookup_factors = '{multi: 8'd1, div: 8'd7};
         default: lookup_factors = '{multi: 8'd4, div: 8'd23};  // 6 and 7.
      endcase
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic mismatch(input string name, input string exp, input string act);
      abort_run($sformatf("[ERROR] %s: expected %s, got %s", name, exp, act));
   endtask

   task automatic check_sel(input string name, input freq_sel_t exp, input freq_sel_t act);
      if (act !== exp) mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
   endtask

   task automatic check_factor(input string name, input clk_factor_t exp,
                               input clk_factor_t act);
      if (act !== exp) mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
   endtask

   // one load frame, 10 bits, opcode then factor.
   task automatic check_frame(input string name, input frame_t frm, input logic [1:0] op,
                              input clk_factor_t factor);
      if (frm.len != 8'd10) begin
         abort_run($sformatf("%s: a frame had %0d bits under progen instead of 10",
                             name, frm.len));
      end
      check_flag(name, op[0], frm.op[0]);
      check_flag(name, op[1], frm.op[1]);
      check_factor(name, factor, frm.factor);
   endtask

   //-----------------------------------------------------------------------
   // stimulus helpers
   //-----------------------------------------------------------------------

   // one cycle strobe, then the drop response.
   task automatic send_request(input string name, input freq_sel_t sel, input logic drop);
      @(posedge clk);
      req_valid <= 1'b1;
      req_sel   <= sel;
      @(posedge clk);
      req_valid <= 1'b0;
      @(posedge clk);
      check_flag(name, drop, req_drop);
   endtask

   task automatic wait_ack();
      do begin
         @(posedge clk);
      end while (freq_ack !== 1'b1);
   endtask

   // frames, single go and reported setting for one programming.
   task automatic verify_programming(input string name, input freq_sel_t sel);
      prog_cmd_t exp;
      frame_t    frm;
      exp = lookup_factors(sel);
      wait_ack();
      check_sel(name, sel, cur_sel);
      if (frame_q.size() != 2) begin
         abort_run($sformatf("%s: %0d load frames were sent instead of 2",
                             name, frame_q.size()));
      end
      frm = frame_q.pop_front();
      check_frame(name, frm, 2'b01, exp.div);   // divide frame first.
      frm = frame_q.pop_front();
      check_frame(name, frm, 2'b11, exp.multi);
      if (go_cnt != go_checked + 1) begin
         abort_run($sformatf("%s: %0d go commands were sent instead of 1",
                             name, go_cnt - go_checked));
      end
      go_checked = go_cnt;
   endtask

   //-----------------------------------------------------------------------
   // directed tests
   //-----------------------------------------------------------------------

   task automatic apply_reset();
      rst_sys <= 1'b1;
      repeat (3) begin
         @(posedge clk);
         check_flag("reset", 1'b1, ddc_rst);
         check_flag("reset", 1'b0, progen);
         check_flag("reset", 1'b0, progdata);
         check_flag("reset", 1'b0, req_drop);
         check_flag("reset", 1'b0, freq_ack);
      end
      rst_sys <= 1'b0;
   endtask

   task automatic run_default_setting();
      verify_programming("default_setting", DEFAULT_SEL);
      check_flag("default_setting", 1'b0, ddc_rst);
   endtask

   task automatic sweep_all_settings();
      for (int s = 0; s < 8; s++) begin
         send_request($sformatf("sweep_%0d", s), freq_sel_t'(s), 1'b0);
         verify_programming($sformatf("sweep_%0d", s), freq_sel_t'(s));
      end
   endtask

   // second request lands while the frames are going out.
   task automatic drop_busy_request();
      send_request("drop_busy", 3'd2, 1'b0);
      send_request("drop_busy", 3'd6, 1'b1);
      verify_programming("drop_busy", 3'd2);
      // a held request would start a frame within two cycles of the ack.
      repeat (5) begin
         @(posedge clk);
         check_flag("drop_busy", 1'b0, progen);
      end
      if ((frame_q.size() != 0) || (go_cnt != go_checked)) begin
         abort_run("drop_busy: the dropped request still produced programming traffic");
      end
      check_sel("drop_busy", 3'd2, cur_sel);
   endtask

   task automatic frame_format();
      send_request("frame_format", 3'd6, 1'b0);
      verify_programming("frame_format", 3'd6);
   endtask

   task automatic random_settings();
      freq_sel_t sel;
      for (int i = 0; i < 10; i++) begin
         sel = freq_sel_t'($urandom % 8);
         send_request($sformatf("random_%0d", i), sel, 1'b0);
         verify_programming($sformatf("random_%0d", i), sel);
      end
   endtask

   initial begin : main
      void'($urandom(20));
      req_valid = 1'b0;
      req_sel   = '0;
      apply_reset();
      run_default_setting();
      sweep_all_settings();
      drop_busy_request();
      frame_format();
      random_settings();
      $display("TEST OK");
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      abort_run("timeout: the tests did not finish within the allowed time");
   end

endmodule

// ==== verilog/dfs_clk_opt_ctrl.sv ====
//--------------------------------------------------------------------------
// dfs clock option controller
// holds the scaled domain in reset, waits out initialisation, programs the
// default setting, then turns frequency requests into factor commands for
// the serializer and reports each completed setting.
//--------------------------------------------------------------------------

module dfs_clk_opt_ctrl
   import dfs_pkg::*;
#(
   parameter freq_sel_t DEFAULT_SEL = '0   // setting programmed after reset.
) (
   input  logic      clk,
   input  logic      rst_sys,

   // requester side.
   input  logic      req_valid,            // single cycle request strobe.
   input  freq_sel_t req_sel,
   output logic      req_drop,             // request ignored, busy.
   output logic      freq_ack,             // new setting active.
   output freq_sel_t cur_sel,              // last completed setting.

   // scaled domain reset.
   output logic      ddc_rst,

   // serializer side.
   output logic      cmd_valid,
   output prog_cmd_t cmd,
   input  logic      prog_done
);

   // wide enough to reach INIT_CYCLES - 1.
   localparam int CNT_W = $clog2(INIT_CYCLES + 1);

   ctrl_state_t      state;
   logic [CNT_W-1:0] init_cnt;
   freq_sel_t        pend_sel;             // setting being programmed.

   logic init_last;
   logic req_take;

   assign init_last = (init_cnt == CNT_W'(INIT_CYCLES - 1));
   assign req_take  = (state == cs_run) && req_valid;

   //-----------------------------------------------------------------------
   // control FSM
   //-----------------------------------------------------------------------

   always_ff @(posedge clk or posedge rst_sys) begin
      if (rst_sys) begin
         state     <= cs_reset_hold;
         init_cnt  <= '0;
         ddc_rst   <= 1'b1;
         cmd_valid <= 1'b0;
         req_drop  <= 1'b0;
         freq_ack  <= 1'b0;
         cur_sel   <= '0;
      end else begin
         // strobes default low.
         cmd_valid <= 1'b0;
         freq_ack  <= 1'b0;

         // any request outside run is dropped and reported.
         req_drop <= req_valid && (state != cs_run);

         // domain reset stays up for one cycle after release.
         ddc_rst <= (state == cs_reset_hold);

         case (state)
            cs_reset_hold: begin
               state <= cs_init;
            end

            cs_init: begin
               init_cnt <= init_cnt + 1'b1;
               if (init_last) begin
                  state     <= cs_load_default;
                  cmd_valid <= 1'b1;         // valid during load_default.
                  init_cnt  <= '0;
               end
            end

            cs_load_default: begin
               state <= cs_wait_done;        // serializer has the command.
            end

            cs_run: begin
               if (req_valid) begin
                  state     <= cs_wait_done;
                  cmd_valid <= 1'b1;
               end
            end

            cs_wait_done: begin
               // commit once the generator reports done.
               if (prog_done) begin
                  state    <= cs_run;
                  freq_ack <= 1'b1;
                  cur_sel  <= pend_sel;
               end
            end

            default: begin
               state <= cs_reset_hold;
            end
         endcase
      end
   end

   //-----------------------------------------------------------------------
   // command payload
   //-----------------------------------------------------------------------

   // loaded one cycle ahead of cmd_valid so the two line up.
   always_ff @(posedge clk) begin
      if (state == cs_init) begin
         pend_sel <= DEFAULT_SEL;
         cmd      <= FACTOR_TABLE[DEFAULT_SEL];
      end else if (req_take) begin
         pend_sel <= req_sel;
         cmd      <= FACTOR_TABLE[req_sel];  // table lookup.
      end
   end

endmodule

// ==== verilog/dfs_pkg.sv ====
//--------------------------------------------------------------------------
// dfs shared definitions
// widths, the programming command, the state encodings and the table of
// multiply and divide factors used to scale the dynamic clock.
//--------------------------------------------------------------------------

package dfs_pkg;

   // widths that carry a meaning.
   typedef logic [2:0] freq_sel_t;     // frequency setting index.
   typedef logic [7:0] clk_factor_t;   // factor minus one, as the generator expects.
   typedef logic [1:0] prog_op_t;      // serial frame opcode.

   // one programming request, both factors travel together.
   typedef struct packed {
      clk_factor_t multi;
      clk_factor_t div;
   } prog_cmd_t;

   //-----------------------------------------------------------------------
   // state encodings
   //-----------------------------------------------------------------------

   // controller FSM.
   typedef enum logic [2:0] {
      cs_reset_hold,                   // domain reset held.
      cs_init,                         // initialisation wait.
      cs_load_default,                 // default setting issued.
      cs_run,                          // accepting requests.
      cs_wait_done                     // generator being programmed.
   } ctrl_state_t;

   // serializer FSM, walked in declaration order.
   typedef enum logic [2:0] {
      ss_idle,
      ss_frame_d,                      // divide load frame.
      ss_gap_d,
      ss_frame_m,                      // multiply load frame.
      ss_gap_m,
      ss_go,                           // go command, single cycle.
      ss_wait_done                     // waiting for progdone.
   } ser_state_t;

   //-----------------------------------------------------------------------
   // constants
   //-----------------------------------------------------------------------

   localparam int INIT_CYCLES = 4;     // cycles spent in init after reset.

   // opcodes, shifted out lsb first ahead of the factor.
   localparam prog_op_t OP_LOAD_D = 2'b01;
   localparam prog_op_t OP_LOAD_M = 2'b11;

   // factors per setting, both stored as factor minus one.
   localparam prog_cmd_t FACTOR_TABLE [8] = '{
      '{multi: 8'd1, div: 8'd2},       // setting 0.
      '{multi: 8'd6, div: 8'd11},      // setting 1.
      '{multi: 8'd1, div: 8'd13},      // setting 2.
      '{multi: 8'd4, div: 8'd11},      // setting 3.
      '{multi: 8'd1, div: 8'd5},       // setting 4.
      '{multi: 8'd1, div: 8'd7},       // setting 5.
      '{multi: 8'd4, div: 8'd23},      // setting 6.
      '{multi: 8'd4, div: 8'd23}       // setting 7, same as 6.
   };

endpackage

// ==== verilog/dfs_prog_serializer.sv ====
//--------------------------------------------------------------------------
// dfs programming serializer
// drives the generator programming port. sends the divide load frame, the
// multiply load frame and the go command, each opcode and factor lsb
// first, then waits for the generator to raise progdone.
//--------------------------------------------------------------------------

module dfs_prog_serializer
   import dfs_pkg::*;
(
   input  logic      clk,
   input  logic      rst_sys,

   // command from the controller.
   input  logic      cmd_valid,
   input  prog_cmd_t cmd,
   output logic      prog_done,            // single cycle, programming complete.

   // generator programming port.
   output logic      progen,
   output logic      progdata,
   input  logic      progdone
);

   // frame is opcode followed by factor.
   localparam int FRAME_LEN = $bits(prog_op_t) + $bits(clk_factor_t);
   localparam int GAP_LEN   = 2;           // idle cycles after each frame.
   localparam int CNT_W     = $clog2(FRAME_LEN);

   ser_state_t           state;
   logic [CNT_W-1:0]     bit_cnt;          // bit or gap cycle within a step.
   logic [FRAME_LEN-1:0] shreg;            // frame being shifted out.
   clk_factor_t          multi_q;          // held until the m frame loads.

   logic in_frame;
   logic frame_last;
   logic gap_last;

   assign in_frame   = (state == ss_frame_d) || (state == ss_frame_m);
   assign frame_last = (bit_cnt == CNT_W'(FRAME_LEN - 1));
   assign gap_last   = (bit_cnt == CNT_W'(GAP_LEN - 1));

   // port outputs decode straight from state.
   assign progen   = in_frame || (state == ss_go);
   assign progdata = in_frame && shreg[0]; // go carries a zero.

   //-----------------------------------------------------------------------
   // sequencing
   //-----------------------------------------------------------------------

   always_ff @(posedge clk or posedge rst_sys) begin
      if (rst_sys) begin
         state     <= ss_idle;
         bit_cnt   <= '0;
         prog_done <= 1'b0;
      end else begin
         prog_done <= 1'b0;

         case (state)
            ss_idle: begin
               bit_cnt <= '0;
               if (cmd_valid) begin
                  state <= ss_frame_d;
               end
            end

            ss_frame_d: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (frame_last) begin
                  state   <= ss_gap_d;
                  bit_cnt <= '0;
               end
            end

            ss_gap_d: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (gap_last) begin
                  state   <= ss_frame_m;
                  bit_cnt <= '0;
               end
            end

            ss_frame_m: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (frame_last) begin
                  state   <= ss_gap_m;
                  bit_cnt <= '0;
               end
            end

            ss_gap_m: begin
               bit_cnt <= bit_cnt + 1'b1;
               if (gap_last) begin
                  state   <= ss_go;
                  bit_cnt <= '0;
               end
            end

            ss_go: begin
               state <= ss_wait_done;        // go is one cycle long.
            end

            ss_wait_done: begin
               // latency set by the generator.
               if (progdone) begin
                  state     <= ss_idle;
                  prog_done <= 1'b1;
               end
            end

            default: begin
               state <= ss_idle;
            end
         endcase
      end
   end

   //-----------------------------------------------------------------------
   // frame data
   //-----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if ((state == ss_idle) && cmd_valid) begin
         shreg   <= {cmd.div, OP_LOAD_D};    // opcode lands in the low bits.
         multi_q <= cmd.multi;
      end else if ((state == ss_gap_d) && gap_last) begin
         shreg <= {multi_q, OP_LOAD_M};
      end else if (in_frame) begin
         shreg <= shreg >> 1;                // next bit to the front.
      end
   end

endmodule

// ==== verilog/dfs_top.sv ====
//--------------------------------------------------------------------------
// dfs top level
// controller and programming serializer for the dynamically scaled clock.
// the default setting is chosen here and handed to the controller.
//--------------------------------------------------------------------------

module dfs_top
   import dfs_pkg::*;
#(
   parameter freq_sel_t DEFAULT_SEL = '0   // programmed without a request.
) (
   input  logic      clk,
   input  logic      rst_sys,

   // requester.
   input  logic      req_valid,
   input  freq_sel_t req_sel,
   output logic      req_drop,
   output logic      freq_ack,
   output freq_sel_t cur_sel,

   // scaled domain.
   output logic      ddc_rst,

   // clock generator programming port.
   output logic      progen,
   output logic      progdata,
   input  logic      progdone
);

   // controller to serializer.
   logic      cmd_valid;
   prog_cmd_t cmd;
   logic      prog_done;

   dfs_clk_opt_ctrl #(
      .DEFAULT_SEL (DEFAULT_SEL)
   ) i_ctrl (
      .clk       (clk),
      .rst_sys   (rst_sys),
      .req_valid (req_valid),
      .req_sel   (req_sel),
      .req_drop  (req_drop),
      .freq_ack  (freq_ack),
      .cur_sel   (cur_sel),
      .ddc_rst   (ddc_rst),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .prog_done (prog_done)
   );

   dfs_prog_serializer i_ser (
      .clk       (clk),
      .rst_sys   (rst_sys),
      .cmd_valid (cmd_valid),
      .cmd       (cmd),
      .prog_done (prog_done),
      .progen    (progen),
      .progdata  (progdata),
      .progdone  (progdone)
   );

endmodule
